/* hdl/idu_pkg.sv */
// widths, opcodes and control codes shared by every block of the decode stage
package idu_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  alu_ctr_t;
  typedef logic [2:0]  mem_op_t;
  typedef logic [2:0]  br_func_t;
  typedef logic [1:0]  b_src_t;
  typedef logic [2:0]  imm_fmt_t;

  localparam int NUM_REGS = 32;

  // rv64i major opcodes
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_W = 7'b0011011;
  localparam logic [6:0] OPC_OP_W     = 7'b0111011;

  localparam alu_ctr_t ALU_ADD      = 5'b00000;
  localparam alu_ctr_t ALU_SUB      = 5'b00001;
  localparam alu_ctr_t ALU_SLT      = 5'b00010;
  localparam alu_ctr_t ALU_SLTU     = 5'b00011;
  localparam alu_ctr_t ALU_XOR      = 5'b00100;
  localparam alu_ctr_t ALU_AND      = 5'b00101;
  localparam alu_ctr_t ALU_OR       = 5'b00110;
  localparam alu_ctr_t ALU_SLL      = 5'b00111;
  localparam alu_ctr_t ALU_SRL      = 5'b01000;
  localparam alu_ctr_t ALU_SRA      = 5'b01001;
  localparam alu_ctr_t ALU_COPY_IMM = 5'b01111; // lui passes imm through
  localparam alu_ctr_t ALU_INVALID  = 5'b11111;

  // stores share the signed load codes
  localparam mem_op_t MEM_LB   = 3'b000;
  localparam mem_op_t MEM_SB   = 3'b000;
  localparam mem_op_t MEM_LBU  = 3'b001;
  localparam mem_op_t MEM_LH   = 3'b010;
  localparam mem_op_t MEM_SH   = 3'b010;
  localparam mem_op_t MEM_LHU  = 3'b011;
  localparam mem_op_t MEM_LW   = 3'b100;
  localparam mem_op_t MEM_SW   = 3'b100;
  localparam mem_op_t MEM_LWU  = 3'b101;
  localparam mem_op_t MEM_LD   = 3'b110;
  localparam mem_op_t MEM_SD   = 3'b110;
  localparam mem_op_t MEM_NONE = 3'b111;

  localparam br_func_t BR_NONE = 3'b000;
  localparam br_func_t BR_JAL  = 3'b001;
  localparam br_func_t BR_JALR = 3'b010;
  localparam br_func_t BR_EQ   = 3'b100;
  localparam br_func_t BR_NE   = 3'b101;
  localparam br_func_t BR_LT   = 3'b110; // signedness comes from the alu code
  localparam br_func_t BR_GE   = 3'b111;

  localparam b_src_t B_RS2  = 2'b00;
  localparam b_src_t B_IMM  = 2'b01;
  localparam b_src_t B_FOUR = 2'b10; // return address pc + 4

  localparam imm_fmt_t FMT_I    = 3'd0;
  localparam imm_fmt_t FMT_U    = 3'd1;
  localparam imm_fmt_t FMT_S    = 3'd2;
  localparam imm_fmt_t FMT_B    = 3'd3;
  localparam imm_fmt_t FMT_J    = 3'd4;
  localparam imm_fmt_t FMT_NONE = 3'd7; // r-type, zero immediate

endpackage

/* hdl/inst_classify.sv */
// combinational rv64i decoder, maps an instruction word to its control codes
`timescale 1ns/1ns

module inst_classify import idu_pkg::*; (
  input  inst_t    i_inst,
  output alu_ctr_t o_alu_ctr,
  output logic     o_alu_a_src,
  output b_src_t   o_alu_b_src,
  output logic     o_word_cut,
  output mem_op_t  o_mem_op,
  output br_func_t o_br_func,
  output logic     o_reg_wr,
  output logic     o_mem_re,
  output logic     o_mem_wr,
  output logic     o_invalid,
  output imm_fmt_t o_imm_fmt
);

  wire [6:0] opcode = i_inst[6:0];
  wire [2:0] funct3 = i_inst[14:12];
  wire [6:0] funct7 = i_inst[31:25];

  // shared by OP and OP_W, word forms only have add/sub/shifts
  function automatic alu_ctr_t r_alu(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic word);
    alu_ctr_t op;
    op = ALU_INVALID;
    case ({f7, f3})
      {7'b0000000, 3'b000}: op = ALU_ADD;
      {7'b0100000, 3'b000}: op = ALU_SUB;
      {7'b0000000, 3'b001}: op = ALU_SLL;
      {7'b0000000, 3'b101}: op = ALU_SRL;
      {7'b0100000, 3'b101}: op = ALU_SRA;
      {7'b0000000, 3'b010}: op = word ? ALU_INVALID : ALU_SLT;
      {7'b0000000, 3'b011}: op = word ? ALU_INVALID : ALU_SLTU;
      {7'b0000000, 3'b100}: op = word ? ALU_INVALID : ALU_XOR;
      {7'b0000000, 3'b110}: op = word ? ALU_INVALID : ALU_OR;
      {7'b0000000, 3'b111}: op = word ? ALU_INVALID : ALU_AND;
      default: ;
    endcase
    return op;
  endfunction

  always_comb begin
    o_alu_ctr   = ALU_INVALID;
    o_alu_a_src = 1'b0;
    o_alu_b_src = B_RS2;
    o_word_cut  = 1'b0;
    o_mem_op    = MEM_NONE;
    o_br_func   = BR_NONE;
    o_reg_wr    = 1'b0;
    o_mem_re    = 1'b0;
    o_mem_wr    = 1'b0;
    o_imm_fmt   = FMT_NONE;
    case (opcode)
      OPC_LUI: begin
        o_alu_ctr   = ALU_COPY_IMM;
        o_alu_b_src = B_IMM;
        o_imm_fmt   = FMT_U;
        o_reg_wr    = 1'b1;
      end
      OPC_AUIPC: begin
        o_alu_ctr   = ALU_ADD;
        o_alu_a_src = 1'b1; // pc
        o_alu_b_src = B_IMM;
        o_imm_fmt   = FMT_U;
        o_reg_wr    = 1'b1;
      end
      OPC_JAL: begin
        o_alu_ctr   = ALU_ADD;
        o_alu_a_src = 1'b1;
        o_alu_b_src = B_FOUR;
        o_br_func   = BR_JAL;
        o_imm_fmt   = FMT_J;
        o_reg_wr    = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          o_alu_ctr   = ALU_ADD;
          o_alu_a_src = 1'b1;
          o_alu_b_src = B_FOUR;
          o_br_func   = BR_JALR;
          o_imm_fmt   = FMT_I;
          o_reg_wr    = 1'b1;
        end
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000: begin o_alu_ctr = ALU_SUB;  o_br_func = BR_EQ; end
          3'b001: begin o_alu_ctr = ALU_SUB;  o_br_func = BR_NE; end
          3'b100: begin o_alu_ctr = ALU_SLT;  o_br_func = BR_LT; end
          3'b101: begin o_alu_ctr = ALU_SLT;  o_br_func = BR_GE; end
          3'b110: begin o_alu_ctr = ALU_SLTU; o_br_func = BR_LT; end
          3'b111: begin o_alu_ctr = ALU_SLTU; o_br_func = BR_GE; end
          default: ;
        endcase
        if (o_br_func != BR_NONE) o_imm_fmt = FMT_B;
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000: o_mem_op = MEM_LB;
          3'b001: o_mem_op = MEM_LH;
          3'b010: o_mem_op = MEM_LW;
          3'b011: o_mem_op = MEM_LD;
          3'b100: o_mem_op = MEM_LBU;
          3'b101: o_mem_op = MEM_LHU;
          3'b110: o_mem_op = MEM_LWU;
          default: ;
        endcase
        if (o_mem_op != MEM_NONE) begin
          o_alu_ctr   = ALU_ADD; // address = rs1 + imm
          o_alu_b_src = B_IMM;
          o_imm_fmt   = FMT_I;
          o_reg_wr    = 1'b1;
          o_mem_re    = 1'b1;
        end
      end
      OPC_STORE: begin
        case (funct3)
          3'b000: o_mem_op = MEM_SB;
          3'b001: o_mem_op = MEM_SH;
          3'b010: o_mem_op = MEM_SW;
          3'b011: o_mem_op = MEM_SD;
          default: ;
        endcase
        if (o_mem_op != MEM_NONE) begin
          o_alu_ctr   = ALU_ADD;
          o_alu_b_src = B_IMM;
          o_imm_fmt   = FMT_S;
          o_mem_wr    = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b000: o_alu_ctr = ALU_ADD;
          3'b010: o_alu_ctr = ALU_SLT;
          3'b011: o_alu_ctr = ALU_SLTU;
          3'b100: o_alu_ctr = ALU_XOR;
          3'b110: o_alu_ctr = ALU_OR;
          3'b111: o_alu_ctr = ALU_AND;
          3'b001: if (funct7[6:1] == 6'b000000) o_alu_ctr = ALU_SLL; // 6-bit shamt
          3'b101: begin
            if (funct7[6:1] == 6'b000000) o_alu_ctr = ALU_SRL;
            else if (funct7[6:1] == 6'b010000) o_alu_ctr = ALU_SRA;
          end
          default: ;
        endcase
        if (o_alu_ctr != ALU_INVALID) begin
          o_alu_b_src = B_IMM;
          o_imm_fmt   = FMT_I;
          o_reg_wr    = 1'b1;
        end
      end
      OPC_OP_IMM_W: begin
        case (funct3)
          3'b000: o_alu_ctr = ALU_ADD;
          3'b001: if (funct7 == 7'b0000000) o_alu_ctr = ALU_SLL;
          3'b101: begin
            if (funct7 == 7'b0000000) o_alu_ctr = ALU_SRL;
            else if (funct7 == 7'b0100000) o_alu_ctr = ALU_SRA;
          end
          default: ;
        endcase
        if (o_alu_ctr != ALU_INVALID) begin
          o_alu_b_src = B_IMM;
          o_imm_fmt   = FMT_I;
          o_reg_wr    = 1'b1;
          o_word_cut  = 1'b1;
        end
      end
      OPC_OP: begin
        o_alu_ctr = r_alu(funct7, funct3, 1'b0);
        o_reg_wr  = (o_alu_ctr != ALU_INVALID);
      end
      OPC_OP_W: begin
        o_alu_ctr  = r_alu(funct7, funct3, 1'b1);
        o_reg_wr   = (o_alu_ctr != ALU_INVALID);
        o_word_cut = (o_alu_ctr != ALU_INVALID);
      end
      default: ;
    endcase
  end

  // all-zero word is treated as a bubble, not an illegal instruction
  assign o_invalid = (o_alu_ctr == ALU_INVALID) && (i_inst != '0);

endmodule

/* hdl/gpr_file.sv */
// 32x64 integer register file, write-back port and reads registered on valid cycles
`timescale 1ns/1ns

module gpr_file import idu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_valid,
  input  reg_addr_t i_raddr1,
  input  reg_addr_t i_raddr2,
  input  logic      i_wen,
  input  reg_addr_t i_waddr,
  input  xlen_t     i_wdata,
  output xlen_t     o_rdata1,
  output xlen_t     o_rdata2
);

  xlen_t regs [1:NUM_REGS-1]; // x0 is not stored

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, a write on the same edge is seen next time
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rdata1 <= '0;
      o_rdata2 <= '0;
    end else if (i_valid) begin
      o_rdata1 <= (i_raddr1 == '0) ? '0 : regs[i_raddr1];
      o_rdata2 <= (i_raddr2 == '0) ? '0 : regs[i_raddr2];
    end
  end

endmodule

/* hdl/imm_stage.sv */
// immediate generation and the decode output register of the stage
`timescale 1ns/1ns

module imm_stage import idu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_valid,
  input  inst_t     i_inst,
  input  alu_ctr_t  i_alu_ctr,
  input  logic      i_alu_a_src,
  input  b_src_t    i_alu_b_src,
  input  logic      i_word_cut,
  input  mem_op_t   i_mem_op,
  input  br_func_t  i_br_func,
  input  logic      i_reg_wr,
  input  logic      i_mem_re,
  input  logic      i_mem_wr,
  input  logic      i_invalid,
  input  imm_fmt_t  i_imm_fmt,
  output logic      o_valid,
  output reg_addr_t o_rd,
  output xlen_t     o_imm,
  output alu_ctr_t  o_alu_ctr,
  output logic      o_alu_a_src,
  output b_src_t    o_alu_b_src,
  output logic      o_word_cut,
  output mem_op_t   o_mem_op,
  output br_func_t  o_br_func,
  output logic      o_reg_wr,
  output logic      o_mem_re,
  output logic      o_mem_wr,
  output logic      o_invalid
);

  xlen_t imm_i, imm_u, imm_s, imm_b, imm_j;
  xlen_t imm_sel;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (i_imm_fmt)
      FMT_I:   imm_sel = imm_i;
      FMT_U:   imm_sel = imm_u;
      FMT_S:   imm_sel = imm_s;
      FMT_B:   imm_sel = imm_b;
      FMT_J:   imm_sel = imm_j;
      default: imm_sel = '0; // r-type and unsupported
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid   <= 1'b0;
      o_reg_wr  <= 1'b0;
      o_mem_re  <= 1'b0;
      o_mem_wr  <= 1'b0;
      o_invalid <= 1'b0;
    end else begin
      o_valid   <= i_valid;
      o_reg_wr  <= i_valid & i_reg_wr;
      o_mem_re  <= i_valid & i_mem_re;
      o_mem_wr  <= i_valid & i_mem_wr;
      o_invalid <= i_valid & i_invalid; // bubbles never flag
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rd        <= i_inst[11:7];
      o_imm       <= imm_sel;
      o_alu_ctr   <= i_alu_ctr;
      o_alu_a_src <= i_alu_a_src;
      o_alu_b_src <= i_alu_b_src;
      o_word_cut  <= i_word_cut;
      o_mem_op    <= i_mem_op;
      o_br_func   <= i_br_func;
    end
  end

endmodule

/* hdl/idu_top.sv */
// top of the decode stage, one instruction in per valid cycle, results one cycle later
`timescale 1ns/1ns

module idu_top import idu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_valid,
  input  inst_t     i_inst,
  input  logic      i_wb_wen,
  input  reg_addr_t i_wb_addr,
  input  xlen_t     i_wb_data,
  output logic      o_valid,
  output reg_addr_t o_rd,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  output xlen_t     o_imm,
  output alu_ctr_t  o_alu_ctr,
  output logic      o_alu_a_src,
  output b_src_t    o_alu_b_src,
  output logic      o_word_cut,
  output mem_op_t   o_mem_op,
  output br_func_t  o_br_func,
  output logic      o_reg_wr,
  output logic      o_mem_re,
  output logic      o_mem_wr,
  output logic      o_invalid
);

  alu_ctr_t  alu_ctr;
  logic      alu_a_src;
  b_src_t    alu_b_src;
  logic      word_cut;
  mem_op_t   mem_op;
  br_func_t  br_func;
  logic      reg_wr;
  logic      mem_re;
  logic      mem_wr;
  logic      invalid;
  imm_fmt_t  imm_fmt;
  reg_addr_t rs1;
  reg_addr_t rs2;

  assign rs1 = i_inst[19:15];
  assign rs2 = i_inst[24:20];

  inst_classify u_classify (
    .i_inst      (i_inst),
    .o_alu_ctr   (alu_ctr),
    .o_alu_a_src (alu_a_src),
    .o_alu_b_src (alu_b_src),
    .o_word_cut  (word_cut),
    .o_mem_op    (mem_op),
    .o_br_func   (br_func),
    .o_reg_wr    (reg_wr),
    .o_mem_re    (mem_re),
    .o_mem_wr    (mem_wr),
    .o_invalid   (invalid),
    .o_imm_fmt   (imm_fmt)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_addr),
    .i_wdata  (i_wb_data),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

  imm_stage u_imm (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_inst      (i_inst),
    .i_alu_ctr   (alu_ctr),
    .i_alu_a_src (alu_a_src),
    .i_alu_b_src (alu_b_src),
    .i_word_cut  (word_cut),
    .i_mem_op    (mem_op),
    .i_br_func   (br_func),
    .i_reg_wr    (reg_wr),
    .i_mem_re    (mem_re),
    .i_mem_wr    (mem_wr),
    .i_invalid   (invalid),
    .i_imm_fmt   (imm_fmt),
    .o_valid     (o_valid),
    .o_rd        (o_rd),
    .o_imm       (o_imm),
    .o_alu_ctr   (o_alu_ctr),
    .o_alu_a_src (o_alu_a_src),
    .o_alu_b_src (o_alu_b_src),
    .o_word_cut  (o_word_cut),
    .o_mem_op    (o_mem_op),
    .o_br_func   (o_br_func),
    .o_reg_wr    (o_reg_wr),
    .o_mem_re    (o_mem_re),
    .o_mem_wr    (o_mem_wr),
    .o_invalid   (o_invalid)
  );

endmodule

/* bench/idu_assert.sv */
// concurrent checks on the decode stage outputs that bind into idu_top
`timescale 1ns/1ns

module idu_assert (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_valid_q,
  input logic i_reg_wr,
  input logic i_mem_re,
  input logic i_mem_wr,
  input logic i_invalid
);

  int fail_cnt = 0;

  a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !i_valid_q)
    else begin
      fail_cnt++;
      $error("o_valid high during reset");
    end

  // enables only travel with a valid result
  a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_valid_q |-> !(i_reg_wr || i_mem_re || i_mem_wr))
    else begin
      fail_cnt++;
      $error("enable high without o_valid");
    end

  a_invalid_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_invalid |-> !(i_reg_wr || i_mem_re || i_mem_wr))
    else begin
      fail_cnt++;
      $error("enable high on an invalid instruction");
    end

endmodule

bind idu_top idu_assert u_assert (
  .i_clk     (i_clk),
  .i_rst_n   (i_rst_n),
  .i_valid_q (o_valid),
  .i_reg_wr  (o_reg_wr),
  .i_mem_re  (o_mem_re),
  .i_mem_wr  (o_mem_wr),
  .i_invalid (o_invalid)
);

/* bench/tb_idu.sv */
// testbench for the decode stage that drives random rv64i words and checks every decoded result
`timescale 1ns/1ns

module tb_idu import idu_pkg::*; ();

  typedef struct packed {
    alu_ctr_t  alu;
    logic      a_src;
    b_src_t    b_src;
    logic      word;
    mem_op_t   mem;
    br_func_t  br;
    logic      reg_wr;
    logic      mem_re;
    logic      mem_wr;
    logic      invalid;
    logic      ctl_only; // illegal word defines only codes and enables
    reg_addr_t rd;
    xlen_t     imm;
    xlen_t     rs1;
    xlen_t     rs2;
  } exp_t;

  logic      i_clk;
  logic      i_rst_n;
  logic      i_valid;
  inst_t     i_inst;
  logic      i_wb_wen;
  reg_addr_t i_wb_addr;
  xlen_t     i_wb_data;
  logic      o_valid;
  reg_addr_t o_rd;
  xlen_t     o_rs1_data;
  xlen_t     o_rs2_data;
  xlen_t     o_imm;
  alu_ctr_t  o_alu_ctr;
  logic      o_alu_a_src;
  b_src_t    o_alu_b_src;
  logic      o_word_cut;
  mem_op_t   o_mem_op;
  br_func_t  o_br_func;
  logic      o_reg_wr;
  logic      o_mem_re;
  logic      o_mem_wr;
  logic      o_invalid;

  xlen_t      gpr_model [NUM_REGS];
  string      test_name;
  int         err_val;
  int         err_other;
  int         n_checked;
  logic       busy;
  logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  logic [2:0] w_f3 [3] = '{3'd0, 3'd1, 3'd5};
  logic [2:0] m_w_f3 [5] = '{3'd0, 3'd4, 3'd5, 3'd6, 3'd7};

  idu_top dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  function automatic xlen_t sext(input xlen_t v, input int bits);
    xlen_t m;
    m = xlen_t'(1) << (bits - 1);
    return (v ^ m) - m;
  endfunction

  function automatic alu_ctr_t base_alu(input logic [2:0] f3, input logic alt);
    alu_ctr_t a;
    case (f3)
      3'd0: a = alt ? ALU_SUB : ALU_ADD;
      3'd1: a = ALU_SLL;
      3'd2: a = ALU_SLT;
      3'd3: a = ALU_SLTU;
      3'd4: a = ALU_XOR;
      3'd5: a = alt ? ALU_SRA : ALU_SRL;
      3'd6: a = ALU_OR;
      default: a = ALU_AND;
    endcase
    return a;
  endfunction

  function automatic exp_t ref_decode(input inst_t w);
    exp_t       e;
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       ok;
    opc = w[6:0];
    f7 = w[31:25];
    f3 = w[14:12];
    e = '0;
    e.alu = ALU_ADD;
    e.mem = MEM_NONE;
    e.br = BR_NONE;
    e.b_src = B_IMM;
    e.rd = w[11:7];
    e.imm = sext(xlen_t'(w[31:20]), 12); // I format unless replaced
    ok = 1'b1;
    case (opc)
      OPC_LUI, OPC_AUIPC: begin
        e.alu = (opc == OPC_LUI) ? ALU_COPY_IMM : ALU_ADD;
        e.a_src = (opc == OPC_AUIPC);
        e.imm = sext({w[31:12], 12'b0}, 32);
      end
      OPC_JAL, OPC_JALR: begin
        ok = (opc == OPC_JAL) || (f3 == 3'd0);
        e.a_src = 1'b1;
        e.b_src = B_FOUR;
        e.br = (opc == OPC_JAL) ? BR_JAL : BR_JALR;
        if (opc == OPC_JAL) e.imm = sext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
      end
      OPC_BRANCH: begin
        ok = (f3[2:1] != 2'b01);
        e.alu = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
        e.br = f3[0] ? (f3[2] ? BR_GE : BR_NE) : (f3[2] ? BR_LT : BR_EQ);
        e.b_src = B_RS2;
        e.imm = sext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
      end
      OPC_LOAD: begin
        ok = (f3 != 3'd7);
        case (f3)
          3'd0: e.mem = MEM_LB;
          3'd1: e.mem = MEM_LH;
          3'd2: e.mem = MEM_LW;
          3'd3: e.mem = MEM_LD;
          3'd4: e.mem = MEM_LBU;
          3'd5: e.mem = MEM_LHU;
          default: e.mem = MEM_LWU;
        endcase
        e.mem_re = 1'b1;
      end
      OPC_STORE: begin
        ok = !f3[2];
        e.mem = (f3[1:0] == 2'd0) ? MEM_SB : (f3[1:0] == 2'd1) ? MEM_SH :
                (f3[1:0] == 2'd2) ? MEM_SW : MEM_SD;
        e.mem_wr = 1'b1;
        e.imm = sext({w[31:25], w[11:7]}, 12);
      end
      OPC_OP_IMM: begin
        if (f3 == 3'd1) ok = (w[31:26] == 6'h00);
        if (f3 == 3'd5) ok = (w[31:26] == 6'h00) || (w[31:26] == 6'h10);
        e.alu = base_alu(f3, (f3 == 3'd5) && w[30]);
      end
      OPC_OP_IMM_W: begin
        ok = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
             (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
        e.alu = base_alu(f3, (f3 == 3'd5) && w[30]);
      end
      OPC_OP, OPC_OP_W: begin
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        if (opc == OPC_OP_W && f3 != 3'd0 && f3 != 3'd1 && f3 != 3'd5) ok = 1'b0;
        e.alu = base_alu(f3, f7[5]);
        e.b_src = B_RS2;
        e.imm = '0;
      end
      default: ok = 1'b0;
    endcase
    e.word = (opc == OPC_OP_IMM_W) || (opc == OPC_OP_W);
    e.reg_wr = (opc != OPC_BRANCH) && (opc != OPC_STORE);
    if (!ok) begin
      e.alu = ALU_INVALID;
      e.mem = MEM_NONE;
      e.br = BR_NONE;
      e.reg_wr = 1'b0;
      e.mem_re = 1'b0;
      e.mem_wr = 1'b0;
      e.invalid = (w != '0);
      e.ctl_only = 1'b1;
    end
    return e;
  endfunction

  task automatic report_mismatch(input string nm, input string field,
                                 input xlen_t exp, input xlen_t act);
    $display("FAIL %s %s expected %h actual %h", nm, field, exp, act);
    err_val++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    err_other++;
  endtask

  // inputs and reset sampled at the rising edge and outputs checked at the next falling edge
  initial begin
    exp_t  e;
    string nm;
    logic  in_rst;
    busy = 1'b0;
    forever begin
      @(posedge i_clk);
      busy = 1'b0;
      in_rst = !i_rst_n;
      if (in_rst) begin
        foreach (gpr_model[r]) gpr_model[r] = '0;
      end else begin
        if (i_valid) begin
          e = ref_decode(i_inst);
          e.rs1 = gpr_model[i_inst[19:15]];
          e.rs2 = gpr_model[i_inst[24:20]];
          nm = test_name;
          busy = 1'b1;
        end
        if (i_wb_wen && i_wb_addr != '0) gpr_model[i_wb_addr] = i_wb_data; // after the read
      end
      @(negedge i_clk);
      if (in_rst) begin
        if (o_valid || o_reg_wr || o_mem_re || o_mem_wr) report_error("outputs active in reset");
      end else if (busy) begin
        n_checked++;
        if (!o_valid) report_error({"o_valid missing for ", nm});
        if (o_alu_ctr !== e.alu) report_mismatch(nm, "alu_ctr", e.alu, o_alu_ctr);
        if (o_mem_op !== e.mem) report_mismatch(nm, "mem_op", e.mem, o_mem_op);
        if (o_br_func !== e.br) report_mismatch(nm, "br_func", e.br, o_br_func);
        if (o_reg_wr !== e.reg_wr) report_mismatch(nm, "reg_wr", e.reg_wr, o_reg_wr);
        if (o_mem_re !== e.mem_re) report_mismatch(nm, "mem_re", e.mem_re, o_mem_re);
        if (o_mem_wr !== e.mem_wr) report_mismatch(nm, "mem_wr", e.mem_wr, o_mem_wr);
        if (o_invalid !== e.invalid) report_mismatch(nm, "invalid", e.invalid, o_invalid);
        if (o_rd !== e.rd) report_mismatch(nm, "rd", e.rd, o_rd);
        if (o_rs1_data !== e.rs1) report_mismatch(nm, "rs1_data", e.rs1, o_rs1_data);
        if (o_rs2_data !== e.rs2) report_mismatch(nm, "rs2_data", e.rs2, o_rs2_data);
        if (!e.ctl_only) begin
          if (o_imm !== e.imm) report_mismatch(nm, "imm", e.imm, o_imm);
          if (o_alu_a_src !== e.a_src) report_mismatch(nm, "a_src", e.a_src, o_alu_a_src);
          if (o_alu_b_src !== e.b_src) report_mismatch(nm, "b_src", e.b_src, o_alu_b_src);
          if (o_word_cut !== e.word) report_mismatch(nm, "word_cut", e.word, o_word_cut);
        end
        busy = 1'b0;
      end else if (o_valid || o_reg_wr || o_mem_re || o_mem_wr) begin
        report_error("output active after an idle cycle");
      end
    end
  end

  task automatic drive(input logic valid, input inst_t inst, input logic wen,
                       input reg_addr_t waddr, input xlen_t wdata, input string name);
    @(negedge i_clk);
    i_valid = valid;
    i_inst = inst;
    i_wb_wen = wen;
    i_wb_addr = waddr;
    i_wb_data = wdata;
    test_name = name;
  endtask

  task automatic issue(input inst_t inst, input string name);
    drive(1'b1, inst, 1'b0, '0, '0, name);
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, $urandom, 1'b0, '0, '0, "idle"); // junk on i_inst
  endtask

  initial begin
    int    k;
    int    n;
    inst_t w;
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_inst = '0;
    i_wb_wen = 1'b0;
    i_wb_addr = '0;
    i_wb_data = '0;
    test_name = "reset";
    err_val = 0;
    err_other = 0;
    n_checked = 0;
    void'($urandom(32'he056));
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    for (k = 0; k < 40; k++) begin
      w = $urandom;
      case ($urandom_range(0, 3))
        0: begin
          w[6:0] = OPC_OP;
          w[14:12] = 3'($urandom_range(0, 7));
          w[31:25] = ((w[14:12] == 3'd0 || w[14:12] == 3'd5) && $urandom_range(0, 1)) ?
                     7'h20 : 7'h00;
        end
        1: begin
          w[6:0] = OPC_OP_W;
          w[14:12] = w_f3[$urandom_range(0, 2)];
          w[31:25] = (w[14:12] != 3'd1 && $urandom_range(0, 1)) ? 7'h20 : 7'h00;
        end
        2: begin
          w[6:0] = OPC_OP_IMM;
          w[14:12] = 3'($urandom_range(0, 7));
          if (w[14:12] == 3'd1) w[31:26] = 6'h00;
          if (w[14:12] == 3'd5) w[31:26] = $urandom_range(0, 1) ? 6'h10 : 6'h00;
        end
        default: begin
          w[6:0] = OPC_OP_IMM_W;
          w[14:12] = w_f3[$urandom_range(0, 2)];
          if (w[14:12] != 3'd0) w[31:25] = (w[14:12] == 3'd5 && $urandom_range(0, 1)) ?
                                           7'h20 : 7'h00;
        end
      endcase
      issue(w, "alu_ops");
    end

    for (k = 0; k < 40; k++) begin
      w = $urandom; // upper bits stay random
      case ($urandom_range(0, 4))
        0: begin
          w[6:0] = OPC_OP_IMM;
          w[14:12] = 3'd0;
        end
        1: w[6:0] = $urandom_range(0, 1) ? OPC_LUI : OPC_AUIPC;
        2: begin
          w[6:0] = OPC_STORE;
          w[14:12] = 3'($urandom_range(0, 3));
        end
        3: begin
          w[6:0] = OPC_BRANCH;
          w[14:12] = br_f3[$urandom_range(0, 5)];
        end
        default: w[6:0] = OPC_JAL;
      endcase
      issue(w, "imm_gen");
    end

    for (k = 0; k < 7; k++) begin
      w = $urandom;
      w[6:0] = OPC_LOAD;
      w[14:12] = 3'(k);
      issue(w, "load");
    end
    for (k = 0; k < 4; k++) begin
      w = $urandom;
      w[6:0] = OPC_STORE;
      w[14:12] = 3'(k);
      issue(w, "store");
    end

    w = $urandom;
    issue({w[31:7], OPC_JAL}, "ctrl_flow");
    issue({w[31:15], 3'd0, w[11:7], OPC_JALR}, "ctrl_flow");
    issue({w[31:7], OPC_AUIPC}, "ctrl_flow");
    issue({w[31:7], OPC_LUI}, "ctrl_flow");
    for (k = 0; k < 6; k++) begin
      w = $urandom;
      w[6:0] = OPC_BRANCH;
      w[14:12] = br_f3[k];
      issue(w, "ctrl_flow");
    end

    for (k = 0; k < NUM_REGS; k++) begin
      drive(1'b0, $urandom, 1'b1, reg_addr_t'(k), {$urandom, $urandom}, "gpr_fill");
    end
    for (k = 0; k < 24; k++) begin
      if (k % 3 != 1) begin // k%3 == 1 re-reads the register written just before
        w = $urandom;
        w[6:0] = OPC_OP;
        w[14:12] = 3'd0;
        w[31:25] = 7'h00;
        if (k % 4 == 0) w[24:20] = 5'd0;
      end
      drive(1'b1, w, (k % 3 == 0), w[19:15], {$urandom, $urandom}, "gpr_read");
    end

    for (k = 0; k < 8; k++) begin
      w = $urandom;
      issue({7'h01, w[24:15], 3'(k), w[11:7], OPC_OP}, "m_ext");
    end
    for (k = 0; k < 5; k++) begin
      w = $urandom;
      issue({7'h01, w[24:15], m_w_f3[k], w[11:7], OPC_OP_W}, "m_ext_w");
    end
    issue(32'h00000073, "system");
    issue(32'h00100073, "system");
    issue(32'h30200073, "system");
    w = $urandom;
    issue({w[31:15], 3'($urandom_range(1, 3)), w[11:7], 7'b1110011}, "system");
    issue('0, "zero_word");
    idle(4);

    // reset while a result sits in the output register
    issue({12'($urandom_range(0, 1023)), 5'd0, 3'd0, 5'd1, OPC_OP_IMM}, "pre_reset");
    @(negedge i_clk);
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    test_name = "reset";
    repeat (2) @(negedge i_clk);
    i_rst_n = 1'b1;
    idle(2);
    for (k = 0; k < 3; k++) begin
      w = $urandom;
      issue({7'h00, w[24:15], 3'd0, w[11:7], OPC_OP}, "post_reset");
    end
    idle(2);

    n = 0;
    while (busy && n < 10) begin
      @(negedge i_clk);
      n++;
    end
    if (busy) report_error("timeout waiting for the last result");

    $display("checked %0d results, %0d value errors, %0d other errors, %0d assert failures",
             n_checked, err_val, err_other, dut.u_assert.fail_cnt);
    if (err_val + err_other + dut.u_assert.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* build.f */
hdl/idu_pkg.sv
hdl/inst_classify.sv
hdl/gpr_file.sv
hdl/imm_stage.sv
hdl/idu_top.sv
bench/idu_assert.sv
bench/tb_idu.sv
